// File: Makefile
TOP  = tb_readout_top
SRCS = $(shell cat compile.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// File: compile.f
design/readout_pkg.sv
design/hit_tagger.sv
design/generic_fifo.sv
design/axil_readout.sv
design/readout_top.sv
testbench/tb_readout_top.sv

// File: design/axil_readout.sv
`timescale 1ns/1ps

module axil_readout import readout_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         reset,
    // Write address and data
    input  logic                         awvalid,
    output logic                         awready,
    input  logic [AXIL_ADDR_W-1:0]       awaddr,
    input  logic                         wvalid,
    output logic                         wready,
    input  logic [AXIL_DATA_W-1:0]       wdata,
    input  logic [AXIL_DATA_W/8-1:0]     wstrb,
    // Write response
    output logic                         bvalid,
    input  logic                         bready,
    output logic [1:0]                   bresp,
    // Read address and data
    input  logic                         arvalid,
    output logic                         arready,
    input  logic [AXIL_ADDR_W-1:0]       araddr,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [AXIL_DATA_W-1:0]       rdata,
    output logic [1:0]                   rresp,
    // FIFO side
    input  hit_word_t                    head_word,
    input  logic                         empty,
    input  logic                         full,
    input  logic [$clog2(DEPTH+1)-1:0]   size,
    output logic                         pop,
    // Tagger side
    input  logic [15:0]                  lost_count,
    output logic                         enable,
    output logic                         clear
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                   wr_hs;
    logic                   rd_hs;
    logic                   ctrl_sel;
    logic [AXIL_DATA_W-1:0] status_word;

    assign wr_hs    = awvalid && awready && wvalid && wready;
    assign rd_hs    = arvalid && arready;
    assign ctrl_sel = (awaddr == REG_CONTROL);  // Only writable register

    // Address and data are taken together in a single cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_hs) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= ctrl_sel ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // The strobes in wstrb are not honoured, a control write updates all bits
    always_ff @(posedge clk) begin
        if (reset) begin
            enable <= 1'b0;
        end else if (wr_hs && ctrl_sel) begin
            enable <= wdata[0];
        end
    end

    assign clear = wr_hs && ctrl_sel && wdata[1];  // Self-clearing, never stored

    // Read side accepts a new address only once the previous data is gone
    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_comb begin
        status_word                                = '0;
        status_word[STATUS_EMPTY_BIT]              = empty;
        status_word[STATUS_FULL_BIT]               = full;
        status_word[STATUS_SIZE_LSB +: 8]          = 8'(size);
        status_word[STATUS_LOST_LSB +: 16]         = lost_count;
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rresp <= RESP_OKAY;
            case (araddr)
                REG_DATA:    rdata <= empty ? '0 : head_word;
                REG_STATUS:  rdata <= status_word;
                REG_CONTROL: rdata <= {{(AXIL_DATA_W-1){1'b0}}, enable};
                default: begin
                    rdata <= '0;
                    rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

    // Head word leaves the FIFO in the same cycle rdata captures it
    assign pop = rd_hs && (araddr == REG_DATA) && !empty;

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid or bresp changed before bready");

endmodule

// File: design/generic_fifo.sv
`timescale 1ns/1ps

module generic_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         push,
    input  payload_t                     push_word,
    input  logic                         pop,
    output payload_t                     head_word,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   size
);

    localparam int PTR_W  = $clog2(DEPTH);
    localparam int SIZE_W = $clog2(DEPTH+1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_next;   // Read address for the prefetched head
    logic             empty_loc; // Raw pointer compare

    // Pointer increment with wrap after the last slot
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH-1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty_loc = (wr_ptr == rd_ptr);
    assign full      = (ptr_inc(wr_ptr) == rd_ptr);  // One slot always stays free

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (pop && !empty_loc) begin
            rd_ptr <= ptr_inc(rd_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (push && !full) begin
            wr_ptr <= ptr_inc(wr_ptr);
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // On a pop, look one slot ahead so empty is right in the next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            empty <= 1'b1;
        end else if (pop && !empty_loc) begin
            empty <= (wr_ptr == ptr_inc(rd_ptr));
        end else begin
            empty <= empty_loc;
        end
    end

    assign rd_next = pop ? ptr_inc(rd_ptr) : rd_ptr;

    always_ff @(posedge clk) begin
        head_word <= mem[rd_next];  // Head is always fetched ahead
    end

    always_comb begin
        if (wr_ptr >= rd_ptr) begin
            size = SIZE_W'(wr_ptr) - SIZE_W'(rd_ptr);
        end else begin
            size = SIZE_W'(wr_ptr) + SIZE_W'(DEPTH) - SIZE_W'(rd_ptr);
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("push while FIFO full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("pop while FIFO empty");

endmodule

// File: design/hit_tagger.sv
`timescale 1ns/1ps

module hit_tagger import readout_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hit_valid,
    input  logic [HIT_DATA_W-1:0] hit_data,
    input  logic                  enable,
    input  logic                  clear,
    input  logic                  full,
    output logic                  push,
    output hit_word_t             push_word,
    output logic [15:0]           lost_count
);

    logic [15:0]           timestamp;
    logic                  hit_q;       // Input stage, hit seen while enabled
    logic [HIT_DATA_W-1:0] hit_data_q;
    logic [15:0]           stamp_q;     // Time of the sampled hit
    logic                  pend_q;      // Tagged word waiting for the FIFO

    // Free-running time base, only advances while the readout is enabled
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            timestamp <= '0;
        end else if (enable) begin
            timestamp <= timestamp + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit_valid && enable;  // Hits are ignored while disabled
        end
    end

    always_ff @(posedge clk) begin
        hit_data_q <= hit_data;
        stamp_q    <= timestamp;
    end

    // Second stage builds the tagged word
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= 1'b0;
        end else begin
            pend_q <= hit_q;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_q) begin
            push_word.timestamp <= stamp_q;
            push_word.data      <= hit_data_q;
        end
    end

    // A pending word is only offered to the FIFO when it has room
    assign push = pend_q && !full;

    // Words that find the FIFO full are dropped here and counted
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            lost_count <= '0;
        end else if (pend_q && full && lost_count != 16'hffff) begin
            lost_count <= lost_count + 16'd1;  // Saturates at all ones
        end
    end

    a_lost_monotonic: assert property (@(posedge clk) disable iff (reset)
        !$past(clear) |-> lost_count >= $past(lost_count))
        else $error("lost_count decreased without a clear");

endmodule

// File: design/readout_pkg.sv
package readout_pkg;

    // Raw hit payload as delivered by the front end
    localparam int HIT_DATA_W = 16;

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    // A tagged hit is exactly one bus word
    typedef struct packed {
        logic [15:0]           timestamp;  // Upper half, cycles counted while enabled
        logic [HIT_DATA_W-1:0] data;       // Lower half, hit data as sampled
    } hit_word_t;

    // Register map
    localparam logic [AXIL_ADDR_W-1:0] REG_DATA    = 4'h0;  // Read pops one tagged word
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS  = 4'h4;  // Read only
    localparam logic [AXIL_ADDR_W-1:0] REG_CONTROL = 4'h8;  // Bit 0 enable, bit 1 clear

    // Field positions inside the status word
    localparam int STATUS_EMPTY_BIT = 0;
    localparam int STATUS_FULL_BIT  = 1;
    localparam int STATUS_SIZE_LSB  = 8;   // 8-bit fill size
    localparam int STATUS_LOST_LSB  = 16;  // 16-bit lost-hit count

endpackage

// File: design/readout_top.sv
`timescale 1ns/1ps

module readout_top import readout_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     hit_valid,
    input  logic [HIT_DATA_W-1:0]    hit_data,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [AXIL_ADDR_W-1:0]   awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [AXIL_DATA_W-1:0]   wdata,
    input  logic [AXIL_DATA_W/8-1:0] wstrb,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [1:0]               bresp,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [AXIL_ADDR_W-1:0]   araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp
);

    logic                            push;
    hit_word_t                       push_word;
    logic                            pop;
    hit_word_t                       head_word;
    logic                            empty;
    logic                            full;
    logic [$clog2(FIFO_DEPTH+1)-1:0] size;
    logic [15:0]                     lost_count;
    logic                            enable;
    logic                            clear;

    hit_tagger u_tagger (
        .clk        (clk),
        .reset      (reset),
        .hit_valid  (hit_valid),
        .hit_data   (hit_data),
        .enable     (enable),
        .clear      (clear),
        .full       (full),
        .push       (push),
        .push_word  (push_word),
        .lost_count (lost_count)
    );

    generic_fifo #(
        .payload_t (hit_word_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .head_word (head_word),
        .empty     (empty),
        .full      (full),
        .size      (size)
    );

    axil_readout #(
        .DEPTH (FIFO_DEPTH)
    ) u_axil (
        .clk        (clk),
        .reset      (reset),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .head_word  (head_word),
        .empty      (empty),
        .full       (full),
        .size       (size),
        .pop        (pop),
        .lost_count (lost_count),
        .enable     (enable),
        .clear      (clear)
    );

endmodule

// File: testbench/tb_readout_top.sv
`timescale 1ns/1ps

module tb_readout_top import readout_pkg::*; ();

    localparam int         FIFO_DEPTH = 16;
    localparam logic [1:0] OKAY       = 2'b00;
    localparam logic [1:0] SLVERR     = 2'b10;

    typedef enum logic [1:0] {STEP_HITS, STEP_WRITE, STEP_READ, STEP_IDLE} step_kind_t;

    typedef struct packed {
        step_kind_t                 kind;
        logic [AXIL_ADDR_W-1:0]     addr;
        logic [AXIL_DATA_W-1:0]     data;     // Write data or expected read data
        logic [AXIL_DATA_W-1:0]     mask;
        logic [1:0]                 resp;
        int                         count;    // Hits in a burst or idle cycles
        int                         spacing;  // Cycles from one hit to the next
    } step_t;

    logic                     clk;
    logic                     reset;
    logic                     hit_valid;
    logic [HIT_DATA_W-1:0]    hit_data;
    logic                     awvalid;
    logic                     awready;
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     wvalid;
    logic                     wready;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     bvalid;
    logic                     bready;
    logic [1:0]               bresp;
    logic                     arvalid;
    logic                     arready;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     rvalid;
    logic                     rready;
    logic [AXIL_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;

    step_t       steps[$];
    logic [15:0] exp_data[$];   // Hit data the FIFO should hold with the oldest first
    int          exp_gap[$];    // Expected timestamp step to the previous word or 0 for the first
    logic [15:0] last_stamp;
    logic        enable_model;
    integer      seed;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    readout_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (.*);

    always #10 clk = ~clk;

    // Ends a run that stalls on a handshake
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    function automatic logic [31:0] status_of(input logic emp, input logic ful,
                                              input int fill, input int lost);
        logic [31:0] word;
        word                           = '0;
        word[STATUS_EMPTY_BIT]         = emp;
        word[STATUS_FULL_BIT]          = ful;
        word[STATUS_SIZE_LSB +: 8]     = fill[7:0];
        word[STATUS_LOST_LSB +: 16]    = lost[15:0];
        return word;
    endfunction

    task automatic add_step(input step_kind_t kind, input logic [3:0] addr,
                            input logic [31:0] data, input logic [1:0] resp,
                            input int count, input int spacing);
        steps.push_back('{kind, addr, data, 32'hffff_ffff, resp, count, spacing});
    endtask

    task automatic add_read(input logic [3:0] addr, input logic [31:0] data,
                            input logic [1:0] resp);
        add_step(STEP_READ, addr, data, resp, 0, 0);
    endtask

    task automatic check_field(input string what, input logic [31:0] got,
                               input logic [31:0] expected, input logic [31:0] mask);
        assert ((got & mask) == (expected & mask)) else begin
            $display("MISMATCH at %0t: %s got %h expected %h (mask %h)",
                     $time, what, got, expected, mask);
            $display("Test failures found");
            $fatal(1, "First mismatch ends the run");
        end
    endtask

    task automatic drive_hits(input int count, input int spacing);
        logic [31:0] rnd;
        int          i;
        int          g;
        for (i = 0; i < count; i++) begin
            @(negedge clk);
            rnd       = $random(seed);
            hit_valid = 1'b1;
            hit_data  = rnd[15:0];
            if (enable_model && exp_data.size() < FIFO_DEPTH - 1) begin
                exp_gap.push_back((i == 0) ? 0 : spacing);
                exp_data.push_back(rnd[15:0]);
            end
            for (g = 1; g < spacing; g++) begin
                @(negedge clk);
                hit_valid = 1'b0;
            end
        end
        @(negedge clk);
        hit_valid = 1'b0;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        @(negedge clk);
        while (!awready) @(negedge clk);
        check_field("wready alongside awready", {31'b0, wready}, 32'h1, 32'hffff_ffff);
        @(negedge clk);  // Handshake took place on the edge just passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    // rready stays low for a while so the slave has to hold its response
    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_hit_word(input logic [31:0] got, input logic [1:0] resp);
        logic [15:0] want;
        int          gap;
        want = exp_data.pop_front();
        gap  = exp_gap.pop_front();
        check_field("hit data", got, {16'h0, want}, 32'h0000_ffff);
        check_field("hit read response", {30'b0, resp}, {30'b0, OKAY}, 32'hffff_ffff);
        if (gap > 0) begin
            check_field("timestamp gap", {16'h0, got[31:16] - last_stamp}, gap, 32'h0000_ffff);
        end
        last_stamp = got[31:16];
    endtask

    task automatic build_table();
        int i;
        add_read(REG_STATUS, status_of(1, 0, 0, 0), OKAY);  // State after reset
        add_read(REG_CONTROL, 32'h0, OKAY);
        add_step(STEP_HITS, 0, 0, OKAY, 3, 1);               // Ignored while disabled
        add_step(STEP_IDLE, 0, 0, OKAY, 6, 0);
        add_read(REG_STATUS, status_of(1, 0, 0, 0), OKAY);
        add_step(STEP_WRITE, REG_CONTROL, 32'h1, OKAY, 0, 0);
        add_step(STEP_HITS, 0, 0, OKAY, 5, 3);
        add_step(STEP_IDLE, 0, 0, OKAY, 6, 0);
        add_read(REG_STATUS, status_of(0, 0, 5, 0), OKAY);
        for (i = 0; i < 5; i++) begin
            add_read(REG_DATA, 32'h0, OKAY);
            add_read(REG_STATUS, status_of(i == 4, 0, 4 - i, 0), OKAY);
        end
        // The last four hits of this burst find the FIFO full
        add_step(STEP_HITS, 0, 0, OKAY, FIFO_DEPTH + 3, 1);
        add_step(STEP_IDLE, 0, 0, OKAY, 6, 0);
        add_read(REG_STATUS, status_of(0, 1, FIFO_DEPTH - 1, 4), OKAY);
        for (i = 0; i < FIFO_DEPTH - 1; i++) begin
            add_read(REG_DATA, 32'h0, OKAY);
        end
        add_read(REG_DATA, 32'h0, OKAY);                     // Empty FIFO reads zero
        add_read(REG_STATUS, status_of(1, 0, 0, 4), OKAY);
        add_read(4'hc, 32'h0, SLVERR);
        add_step(STEP_WRITE, 4'hc, 32'h0, SLVERR, 0, 0);
        add_read(REG_CONTROL, 32'h1, OKAY);
        add_step(STEP_WRITE, REG_CONTROL, 32'h3, OKAY, 0, 0);  // Clear with enable kept
        add_read(REG_STATUS, status_of(1, 0, 0, 0), OKAY);
        add_read(REG_CONTROL, 32'h1, OKAY);
        add_step(STEP_HITS, 0, 0, OKAY, 2, 4);
        add_step(STEP_IDLE, 0, 0, OKAY, 6, 0);
        add_read(REG_DATA, 32'h0, OKAY);
        add_read(REG_DATA, 32'h0, OKAY);
        add_read(REG_STATUS, status_of(1, 0, 0, 0), OKAY);
    endtask

    initial begin
        step_t       st;
        logic [31:0] got;
        logic [1:0]  resp;
        clk          = 1'b0;
        reset        = 1'b1;
        hit_valid    = 1'b0;
        hit_data     = '0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        wstrb        = '1;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        seed         = 32'hbf7f_31ca;
        enable_model = 1'b0;
        last_stamp   = '0;
        build_table();
        cycle_limit = steps.size() * 40;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) begin
            st = steps[i];
            case (st.kind)
                STEP_HITS: drive_hits(st.count, st.spacing);
                STEP_IDLE: repeat (st.count) @(negedge clk);
                STEP_WRITE: begin
                    axi_write(st.addr, st.data, resp);
                    check_field($sformatf("step %0d write response", i), {30'b0, resp},
                                {30'b0, st.resp}, 32'hffff_ffff);
                    if (st.addr == REG_CONTROL) begin
                        enable_model = st.data[0];
                    end
                end
                default: begin
                    axi_read(st.addr, got, resp);
                    if (st.addr == REG_DATA && exp_data.size() > 0) begin
                        check_hit_word(got, resp);
                    end else begin
                        check_field($sformatf("step %0d read data", i), got, st.data, st.mask);
                        check_field($sformatf("step %0d read response", i), {30'b0, resp},
                                    {30'b0, st.resp}, 32'hffff_ffff);
                    end
                end
            endcase
        end
        $display("All tests passed!");
        $finish;
    end

endmodule
